// File: build.f
+incdir+include
rtl/cpuPkg.sv
rtl/regFileIf.sv
rtl/microcodeStore.sv
rtl/microSequencer.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/addressUnit.sv
rtl/cpuTop.sv
verif/cpuChecker.sv
verif/tbCpu.sv

// File: include/microcodeTable.svh
`ifndef MICROCODE_TABLE_SVH
`define MICROCODE_TABLE_SVH

// Flow entry points, fetch flow sits at FLOW_FETCH
localparam flowIdx_t FLOW_LD_IMM = 4'd2;
localparam flowIdx_t FLOW_MOVE   = 4'd4;
localparam flowIdx_t FLOW_STORE  = 4'd5;
localparam flowIdx_t FLOW_ALU    = 4'd6;
localparam flowIdx_t FLOW_JR     = 4'd7;
localparam flowIdx_t FLOW_HALT   = 4'd9;
localparam flowIdx_t FLOW_NOP    = 4'd10;

localparam uop_t MICROCODE [16] = '{
  '{cmd: fetchOp,  eof: 1'b0, incPc: 1'b0},  // 0  opcode fetch
  '{cmd: latchOp,  eof: 1'b0, incPc: 1'b1},  // 1  dispatch
  '{cmd: fetchImm, eof: 1'b0, incPc: 1'b0},  // 2  LD r,n
  '{cmd: writeImm, eof: 1'b1, incPc: 1'b1},  // 3
  '{cmd: moveReg,  eof: 1'b1, incPc: 1'b0},  // 4  LD r,r'
  '{cmd: storeHl,  eof: 1'b1, incPc: 1'b0},  // 5  LD (HL),r
  '{cmd: aluOp,    eof: 1'b1, incPc: 1'b0},  // 6  ALU, INC, DEC
  '{cmd: fetchImm, eof: 1'b0, incPc: 1'b1},  // 7  JR cc, step past displacement
  '{cmd: jumpRel,  eof: 1'b1, incPc: 1'b0},  // 8
  '{cmd: halt,     eof: 1'b1, incPc: 1'b0},  // 9  HALT
  '{cmd: nop,      eof: 1'b1, incPc: 1'b0},  // 10 unsupported opcodes
  '{cmd: nop,      eof: 1'b1, incPc: 1'b0},  // 11 unused from here
  '{cmd: nop,      eof: 1'b1, incPc: 1'b0},
  '{cmd: nop,      eof: 1'b1, incPc: 1'b0},
  '{cmd: nop,      eof: 1'b1, incPc: 1'b0},
  '{cmd: nop,      eof: 1'b1, incPc: 1'b0}
};

`endif

// File: rtl/addressUnit.sv
`timescale 1ns/1ps

module addressUnit import cpuPkg::*;
#(
  parameter logic [15:0] resetPc = 16'h0000
)
(
  input  logic        iClock,
  input  logic        reset,
  input  uop_t        curStep,
  input  logic        takeJump,
  input  logic [7:0]  memReadData,
  input  logic [15:0] hl,
  regFileIf.alu       rf,
  output logic [15:0] memAddr,
  output logic [7:0]  memWriteData
);

  logic [15:0] pc;
  logic [15:0] displacement;

  assign displacement = {{8{memReadData[7]}}, memReadData};  // Signed JR offset

  // ----------------------------------------
  // Program counter
  always_ff @(posedge iClock)
  begin
    if (reset)
      pc <= resetPc;
    else if (curStep.cmd == jumpRel && takeJump)
      pc <= pc + displacement;   // PC already past the displacement byte
    else if (curStep.incPc)
      pc <= pc + 16'd1;
  end

  // Memory address select
  always_comb
  begin
    if (curStep.cmd == storeHl)
      memAddr = hl;
    else
      memAddr = pc;
  end

  assign memWriteData = rf.readData;  // Source register of LD (HL),r

endmodule

// File: rtl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import cpuPkg::*;
(
  input  logic       iClock,
  input  logic       reset,
  input  uop_t       curStep,
  input  logic [7:0] opcode,
  input  logic [7:0] memReadData,
  regFileIf.alu      rf,
  output flags_t     flags
);

  aluFunc_t   func;
  logic [8:0] result;   // Bit 8 is carry or borrow

  always_comb
  begin
    if (opcode[7:6] == GROUP_ALU)
    begin
      case (opcode[5:3])
        ALU_FN_ADD: func = aluAdd;
        ALU_FN_SUB: func = aluSub;
        ALU_FN_AND: func = aluAnd;
        ALU_FN_XOR: func = aluXor;
        default:    func = aluOr;
      endcase
    end
    else
      func = opcode[0] ? aluDec : aluInc;
  end

  always_comb
  begin
    case (func)
      aluAdd:  result = {1'b0, rf.regA} + {1'b0, rf.readData};
      aluSub:  result = {1'b0, rf.regA} - {1'b0, rf.readData};
      aluAnd:  result = {1'b0, rf.regA & rf.readData};
      aluXor:  result = {1'b0, rf.regA ^ rf.readData};
      aluOr:   result = {1'b0, rf.regA | rf.readData};
      aluInc:  result = {1'b0, rf.readData + 8'd1};
      default: result = {1'b0, rf.readData - 8'd1};
    endcase
  end

  always_comb
  begin
    case (curStep.cmd)
      writeImm: rf.writeData = memReadData;
      aluOp:    rf.writeData = result[7:0];
      default:  rf.writeData = rf.readData;   // moveReg
    endcase
  end

  always_ff @(posedge iClock)
  begin
    if (reset)
      flags <= '0;
    else if (curStep.cmd == aluOp)
    begin
      flags.z <= (result[7:0] == 8'h00);
      if (func != aluInc && func != aluDec)
        flags.c <= result[8];   // INC and DEC leave C alone
    end
  end

endmodule

// File: rtl/cpuPkg.sv
package cpuPkg;

  // Register index in Z80 operand order, B C D E H L (HL) A
  typedef logic [2:0] regIdx_t;

  localparam regIdx_t REG_IDX_HL_MEM = 3'd6;
  localparam regIdx_t REG_IDX_A      = 3'd7;

  // ----------------------------------------
  // Opcode fields
  localparam logic [7:0] OPCODE_HALT = 8'h76;

  localparam logic [1:0] GROUP_MISC = 2'b00; // LD r,n  INC  DEC  JR cc
  localparam logic [1:0] GROUP_LOAD = 2'b01; // LD r,r'  LD (HL),r  HALT
  localparam logic [1:0] GROUP_ALU  = 2'b10; // A op r

  localparam logic [2:0] ALU_FN_ADD = 3'b000;
  localparam logic [2:0] ALU_FN_SUB = 3'b010;
  localparam logic [2:0] ALU_FN_AND = 3'b100;
  localparam logic [2:0] ALU_FN_XOR = 3'b101;
  localparam logic [2:0] ALU_FN_OR  = 3'b110;

  // Jump condition in opcode bits 4:3
  localparam logic [1:0] CC_NZ = 2'b00;
  localparam logic [1:0] CC_Z  = 2'b01;
  localparam logic [1:0] CC_NC = 2'b10;

  // ----------------------------------------
  // Microcode
  typedef enum logic [3:0] {
    fetchOp, latchOp, fetchImm, writeImm, moveReg,
    storeHl, aluOp, jumpRel, halt, nop
  } uopCmd_t;

  typedef struct packed {
    uopCmd_t cmd;
    logic    eof;   // Last step of the flow
    logic    incPc;
  } uop_t;

  typedef logic [3:0] flowIdx_t;

  localparam flowIdx_t FLOW_FETCH = 4'd0;
  localparam uop_t UOP_IDLE = '{cmd: nop, eof: 1'b0, incPc: 1'b0};

  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluXor, aluOr, aluInc, aluDec
  } aluFunc_t;

  typedef struct packed {
    logic z;
    logic c;
  } flags_t;

endpackage

// File: rtl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop import cpuPkg::*;
#(
  parameter logic [15:0] resetPc = 16'h0000
)
(
  input  logic        iClock,
  input  logic        reset,
  output logic [15:0] memAddr,
  output logic        memReadRequest,
  input  logic [7:0]  memReadData,
  output logic [7:0]  memWriteData,
  output logic        memWriteEnable,
  output logic        halted
);

  regFileIf rf ();

  flowIdx_t    flowIdx;
  flowIdx_t    microPc;
  uop_t        step;
  uop_t        curStep;
  logic [7:0]  opcode;
  flags_t      flags;
  logic        takeJump;
  logic [15:0] hl;

  microSequencer sequencer (
    .iClock(iClock), .reset(reset), .memReadData(memReadData), .flags(flags),
    .flowIdx(flowIdx), .microPc(microPc), .step(step), .opcode(opcode),
    .curStep(curStep), .takeJump(takeJump), .memReadRequest(memReadRequest),
    .memWriteEnable(memWriteEnable), .halted(halted), .rf(rf.seq)
  );

  microcodeStore store (.opcode(opcode), .microPc(microPc), .flowIdx(flowIdx), .step(step));

  registerFile regs (.iClock(iClock), .reset(reset), .rf(rf.regs), .hl(hl));

  aluUnit alu (
    .iClock(iClock), .reset(reset), .curStep(curStep), .opcode(opcode),
    .memReadData(memReadData), .rf(rf.alu), .flags(flags)
  );

  addressUnit #(.resetPc(resetPc)) addr (
    .iClock(iClock), .reset(reset), .curStep(curStep), .takeJump(takeJump),
    .memReadData(memReadData), .hl(hl), .rf(rf.alu), .memAddr(memAddr),
    .memWriteData(memWriteData)
  );

endmodule

// File: rtl/microSequencer.sv
`timescale 1ns/1ps

module microSequencer import cpuPkg::*;
(
  input  logic       iClock,
  input  logic       reset,
  input  logic [7:0] memReadData,
  input  flags_t     flags,
  input  flowIdx_t   flowIdx,   // Dispatched flow for the opcode on the bus
  output flowIdx_t   microPc,
  input  uop_t       step,
  output logic [7:0] opcode,
  output uop_t       curStep,
  output logic       takeJump,
  output logic       memReadRequest,
  output logic       memWriteEnable,
  output logic       halted,
  regFileIf.seq      rf
);

  typedef enum logic [2:0] {
    stateAfterReset, stateStartFlow, stateRunFlow, stateEndFlow, stateHalted
  } seqState_t;

  seqState_t  state;
  seqState_t  nextState;
  logic [7:0] opcodeReg;
  logic       flowEnable;
  logic       condMet;

  assign flowEnable = (state == stateRunFlow);
  assign curStep    = flowEnable ? step : UOP_IDLE;

  // Opcode is still on the bus during latchOp
  assign opcode = (curStep.cmd == latchOp) ? memReadData : opcodeReg;

  // ----------------------------------------
  // Flow FSM
  always_comb
  begin
    case (state)
      stateAfterReset: nextState = stateStartFlow;
      stateStartFlow:  nextState = stateRunFlow;
      stateRunFlow:    nextState = curStep.eof ? stateEndFlow : stateRunFlow;
      stateEndFlow:    nextState = halted ? stateHalted : stateStartFlow;
      default:         nextState = stateHalted;
    endcase
  end

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      state     <= stateAfterReset;
      microPc   <= FLOW_FETCH;
      opcodeReg <= 8'h00;
      halted    <= 1'b0;
    end
    else
    begin
      state <= nextState;
      if (state == stateStartFlow)
        microPc <= FLOW_FETCH;
      else if (curStep.cmd == latchOp)
        microPc <= flowIdx;
      else if (flowEnable)
        microPc <= microPc + 4'd1;
      if (curStep.cmd == latchOp)
        opcodeReg <= memReadData;
      if (curStep.cmd == halt)
        halted <= 1'b1;   // Held until reset
    end
  end

  // ----------------------------------------
  // Step decode
  always_comb
  begin
    memReadRequest = 1'b0;
    memWriteEnable = 1'b0;
    rf.readSel     = opcode[2:0];
    rf.writeSel    = opcode[5:3];
    rf.writeEnable = 1'b0;
    case (curStep.cmd)
      fetchOp, fetchImm: memReadRequest = 1'b1;
      writeImm, moveReg: rf.writeEnable = 1'b1;
      storeHl:           memWriteEnable = 1'b1;
      aluOp:
      begin
        rf.writeEnable = 1'b1;
        if (opcode[7:6] == GROUP_ALU)
          rf.writeSel = REG_IDX_A;
        else
          rf.readSel = opcode[5:3];  // INC and DEC work in place
      end
      default: ;
    endcase
  end

  always_comb
  begin
    case (opcode[4:3])
      CC_NZ:   condMet = !flags.z;
      CC_Z:    condMet = flags.z;
      CC_NC:   condMet = !flags.c;
      default: condMet = flags.c;
    endcase
  end

  assign takeJump = (curStep.cmd == jumpRel) && condMet;

  // No bus traffic once HALT has run
  busQuietHalted: assert property (@(posedge iClock) disable iff (reset)
    halted |-> !memReadRequest && !memWriteEnable);

  // Dispatch never sends a (HL) destination to a register write
  noHlWrite: assert property (@(posedge iClock) disable iff (reset)
    rf.writeEnable |-> rf.writeSel != REG_IDX_HL_MEM);

endmodule

// File: rtl/microcodeStore.sv
`timescale 1ns/1ps

module microcodeStore import cpuPkg::*;
(
  input  logic [7:0] opcode,
  input  flowIdx_t   microPc,
  output flowIdx_t   flowIdx,
  output uop_t       step
);

  `include "microcodeTable.svh"

  regIdx_t dst;
  regIdx_t src;

  assign dst  = opcode[5:3];
  assign src  = opcode[2:0];
  assign step = MICROCODE[microPc];

  always_comb
  begin
    flowIdx = FLOW_NOP;   // Anything not listed below
    case (opcode[7:6])
      GROUP_MISC:
      begin
        if (dst != REG_IDX_HL_MEM && src == 3'b110)
          flowIdx = FLOW_LD_IMM;
        else if (dst != REG_IDX_HL_MEM && src[2:1] == 2'b10)
          flowIdx = FLOW_ALU;   // INC r, DEC r
        else if (opcode[5] && src == 3'b000)
          flowIdx = FLOW_JR;
      end
      GROUP_LOAD:
      begin
        if (opcode == OPCODE_HALT)
          flowIdx = FLOW_HALT;
        else if (dst == REG_IDX_HL_MEM)
          flowIdx = FLOW_STORE;
        else if (src != REG_IDX_HL_MEM)
          flowIdx = FLOW_MOVE;
      end
      GROUP_ALU:
        if (src != REG_IDX_HL_MEM &&
            dst inside {ALU_FN_ADD, ALU_FN_SUB, ALU_FN_AND, ALU_FN_XOR, ALU_FN_OR})
          flowIdx = FLOW_ALU;
      default: ;
    endcase
  end

endmodule

// File: rtl/regFileIf.sv
`timescale 1ns/1ps

interface regFileIf import cpuPkg::*; ();

  regIdx_t    readSel;
  logic [7:0] readData;
  regIdx_t    writeSel;
  logic [7:0] writeData;
  logic       writeEnable;
  logic [7:0] regA;     // Accumulator, always visible to the ALU

  modport seq  (output readSel, output writeSel, output writeEnable);
  modport alu  (output writeData, input readData, input regA);
  modport regs (input readSel, input writeSel, input writeData, input writeEnable,
                output readData, output regA);

endinterface

// File: rtl/registerFile.sv
`timescale 1ns/1ps

module registerFile import cpuPkg::*;
(
  input  logic        iClock,
  input  logic        reset,
  regFileIf.regs      rf,
  output logic [15:0] hl
);

  // Slot 6 is the (HL) operand and holds no register
  logic [7:0] regBank [8];

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      for (int i = 0; i < 8; i++)
        regBank[i] <= 8'h00;
    end
    else if (rf.writeEnable && rf.writeSel != REG_IDX_HL_MEM)
      regBank[rf.writeSel] <= rf.writeData;
  end

  // Same-cycle read returns the value before the write
  always_comb
  begin
    if (rf.readSel == REG_IDX_HL_MEM)
      rf.readData = 8'h00;
    else
      rf.readData = regBank[rf.readSel];
  end

  assign rf.regA = regBank[REG_IDX_A];
  assign hl      = {regBank[3'd4], regBank[3'd5]};  // H high, L low

endmodule

// File: verif/cpuChecker.sv
`timescale 1ns/1ps

module cpuChecker
(
  input  logic        iClock,
  input  logic        reset,
  input  logic [15:0] memAddr,
  input  logic        memReadRequest,
  input  logic [7:0]  memWriteData,
  input  logic        memWriteEnable,
  input  logic        halted,
  output int          errorCount
);

  logic [15:0] expAddr [$];   // Expected writes, oldest first
  logic [7:0]  expData [$];
  int          valueErrors = 0;
  int          protocolErrors = 0;
  int          writesSeen = 0;
  bit          haltSeen = 1'b0;

  assign errorCount = valueErrors + protocolErrors;

  // ----------------------------------------
  // Expectation loading, called from the testbench top
  function automatic void startProgram();
    expAddr.delete();
    expData.delete();
    haltSeen = 1'b0;
  endfunction

  function automatic void expectWrite(input logic [15:0] addr, input logic [7:0] data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endfunction

  function automatic void endProgram(input string name);
    if (!haltSeen)
    begin
      $display("%s: the CPU never raised halted", name);
      protocolErrors++;
    end
  endfunction

  function automatic void printSummary();
    $display("Checks: %0d writes compared, %0d value errors, %0d protocol errors",
             writesSeen, valueErrors, protocolErrors);
  endfunction

  // ----------------------------------------
  // Bus monitor
  task automatic compareWrite();
    if (haltSeen)
    begin
      $display("Write to %h at %0d ns after the CPU halted", memAddr, $time);
      protocolErrors++;
    end
    else if (expAddr.size() == 0)
    begin
      $display("Extra write to %h at %0d ns, none expected", memAddr, $time);
      protocolErrors++;
    end
    else
    begin
      if (memAddr !== expAddr[0])
      begin
        $display("** Error at %0d ns: memAddr is %h, expected %h", $time, memAddr, expAddr[0]);
        valueErrors++;
      end
      if (memWriteData !== expData[0])
      begin
        $display("** Error at %0d ns: memWriteData is %h, expected %h",
                 $time, memWriteData, expData[0]);
        valueErrors++;
      end
      void'(expAddr.pop_front());
      void'(expData.pop_front());
      writesSeen++;
    end
  endtask

  // Sampled mid-cycle, away from the clock edge
  always @(negedge iClock)
  begin
    if (!reset)
    begin
      if (memWriteEnable)
        compareWrite();
      if (haltSeen && memReadRequest)
      begin
        $display("Read request at %0d ns after the CPU halted", $time);
        protocolErrors++;
      end
      if (halted && !haltSeen)
      begin
        haltSeen = 1'b1;
        if (expAddr.size() != 0)
        begin
          $display("CPU halted with %0d expected writes missing", expAddr.size());
          protocolErrors++;
        end
      end
    end
  end

endmodule

// File: verif/tbCpu.sv
`timescale 1ns/1ps

module tbCpu import cpuPkg::*; ();

  localparam int         memSize  = 1024;
  localparam logic [7:0] dataPage = 8'h03;   // Stores land in 0x0380 to 0x03FF
  localparam logic [2:0] aluFns [5] = '{ALU_FN_ADD, ALU_FN_SUB, ALU_FN_AND, ALU_FN_XOR,
                                        ALU_FN_OR};
  // Single-byte opcodes outside the kept set
  localparam logic [7:0] oddOps [10] = '{8'h00, 8'h07, 8'h37, 8'h3f, 8'h46, 8'h86, 8'h88,
                                         8'h98, 8'hb8, 8'h34};

  logic        iClock = 1'b0;
  logic        reset = 1'b1;
  logic [7:0]  memReadData = 8'h00;
  logic [15:0] memAddr;
  logic        memReadRequest;
  logic [7:0]  memWriteData;
  logic        memWriteEnable;
  logic        halted;
  int          errorCount;

  logic [7:0]  mem [memSize];
  int          progLen;
  time         deadline = 1000;
  logic [15:0] refAddr [$];
  logic [7:0]  refData [$];

  always #2 iClock = ~iClock;

  cpuTop #(.resetPc(16'h0000)) uut (
    .iClock(iClock), .reset(reset), .memAddr(memAddr), .memReadRequest(memReadRequest),
    .memReadData(memReadData), .memWriteData(memWriteData),
    .memWriteEnable(memWriteEnable), .halted(halted)
  );

  cpuChecker check (
    .iClock(iClock), .reset(reset), .memAddr(memAddr), .memReadRequest(memReadRequest),
    .memWriteData(memWriteData), .memWriteEnable(memWriteEnable), .halted(halted),
    .errorCount(errorCount)
  );

  // Byte memory answering reads one cycle after the request
  always @(posedge iClock)
  begin
    if (memReadRequest)
      memReadData <= mem[memAddr[9:0]];
    if (memWriteEnable)
      mem[memAddr[9:0]] <= memWriteData;
  end

  // ----------------------------------------
  // Program assembly
  function automatic void emit(input logic [7:0] b);
    mem[progLen] = b;
    progLen++;
  endfunction

  function automatic void loadImm(input regIdx_t r, input logic [7:0] n);
    emit({GROUP_MISC, r, 3'b110});
    emit(n);
  endfunction

  function automatic void move(input regIdx_t d, input regIdx_t s);
    emit({GROUP_LOAD, d, s});
  endfunction

  function automatic void store(input regIdx_t s);
    emit({GROUP_LOAD, REG_IDX_HL_MEM, s});
  endfunction

  function automatic void aluWith(input logic [2:0] fn, input regIdx_t s);
    emit({GROUP_ALU, fn, s});
  endfunction

  function automatic void incDec(input regIdx_t r, input logic isDec);
    emit({GROUP_MISC, r, 2'b10, isDec});
  endfunction

  function automatic void jumpIf(input logic [1:0] cc, input logic [7:0] disp);
    emit({GROUP_MISC, 1'b1, cc, 3'b000});
    emit(disp);
  endfunction

  // Any register but H and L
  function automatic regIdx_t randomReg();
    int k;
    k = $urandom_range(4);
    return (k == 4) ? REG_IDX_A : regIdx_t'(k);
  endfunction

  function automatic regIdx_t randomSrc();
    int k;
    k = $urandom_range(6);
    return (k == 6) ? REG_IDX_A : regIdx_t'(k);
  endfunction

  function automatic logic [7:0] edgeByte();
    case ($urandom_range(3))
      0:       return 8'h00;
      1:       return 8'h01;
      2:       return 8'hff;
      default: return 8'($urandom);
    endcase
  endfunction

  // One kept instruction or a JR with the store it may skip
  function automatic int randomInstr();
    case ($urandom_range(5))
      0: loadImm(randomReg(), 8'($urandom));
      1: move(randomReg(), randomSrc());
      2: store(randomSrc());
      3: aluWith(aluFns[$urandom_range(4)], randomSrc());
      4: incDec(randomReg(), 1'($urandom));
      default:
      begin
        jumpIf(2'($urandom), 8'h01);
        store(randomSrc());
        return 2;
      end
    endcase
    return 1;
  endfunction

  function automatic void beginProgram();
    for (int a = 0; a < memSize; a++)
      mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
    progLen = 0;
    loadImm(3'd4, dataPage);
    loadImm(3'd5, {1'b1, 7'($urandom)});   // L in 0x80 to 0xFF
  endfunction

  // ----------------------------------------
  // Instruction-level reference filling refAddr and refData
  function automatic int runReference();
    logic [7:0] regs [8];
    logic [7:0] op;
    logic [7:0] disp;
    logic [2:0] d;
    logic [2:0] s;
    logic [9:0] pc;
    logic       z;
    logic       c;
    logic       cond;
    int         a;
    int         b;
    int         res;
    int         count;
    regs = '{default: 8'h00};
    z = 1'b0;
    c = 1'b0;
    pc = '0;
    count = 0;
    refAddr.delete();
    refData.delete();
    while (count < 2000)
    begin
      op = mem[pc];
      d = op[5:3];
      s = op[2:0];
      pc++;
      count++;
      if (op == OPCODE_HALT)
        return count;
      case (op[7:6])
        GROUP_MISC:
          if (s == 3'd6 && d != 3'd6)   // LD r,n
          begin
            regs[d] = mem[pc];
            pc++;
          end
          else if (s[2:1] == 2'b10 && d != 3'd6)   // INC r and DEC r keep C
          begin
            regs[d] = s[0] ? regs[d] - 8'd1 : regs[d] + 8'd1;
            z = (regs[d] == 8'h00);
          end
          else if (op[5] && s == 3'd0)   // JR cc,e
          begin
            disp = mem[pc];
            pc++;
            case (op[4:3])
              CC_NZ:   cond = !z;
              CC_Z:    cond = z;
              CC_NC:   cond = !c;
              default: cond = c;
            endcase
            if (cond)
              pc = pc + {{2{disp[7]}}, disp};
          end
        GROUP_LOAD:
          if (d == 3'd6)
          begin
            refAddr.push_back({regs[4], regs[5]});
            refData.push_back(regs[s]);
          end
          else if (s != 3'd6)
            regs[d] = regs[s];
        GROUP_ALU:
          if (s != 3'd6 && d inside {ALU_FN_ADD, ALU_FN_SUB, ALU_FN_AND, ALU_FN_XOR, ALU_FN_OR})
          begin
            a = regs[7];
            b = regs[s];
            case (d)
              ALU_FN_ADD: res = a + b;
              ALU_FN_SUB: res = a - b;
              ALU_FN_AND: res = a & b;
              ALU_FN_XOR: res = a ^ b;
              default:    res = a | b;
            endcase
            regs[7] = 8'(res);
            z = (regs[7] == 8'h00);
            c = (d == ALU_FN_ADD) ? (res > 255) : (d == ALU_FN_SUB) ? (res < 0) : 1'b0;
          end
        default: ;   // Unsupported opcodes run as no-operation
      endcase
    end
    return count;
  endfunction

  // ----------------------------------------
  task automatic runProgram(input string name);
    int instrCount;
    emit(OPCODE_HALT);
    instrCount = runReference();
    deadline = $time + instrCount * 6 * 4 + 200;
    @(posedge iClock);
    reset <= 1'b1;
    repeat (4) @(posedge iClock);
    check.startProgram();
    foreach (refAddr[i])
      check.expectWrite(refAddr[i], refData[i]);
    reset <= 1'b0;
    while (!halted && $time < deadline - 100)
      @(negedge iClock);
    repeat (10) @(negedge iClock);   // Watch for stray writes after halt
    check.endProgram(name);
  endtask

  task automatic testLoadStore();
    regIdx_t order [5] = '{3'd0, 3'd1, 3'd2, 3'd3, REG_IDX_A};
    beginProgram();
    foreach (order[i])
      loadImm(order[i], 8'($urandom));
    for (int r = 0; r < 8; r++)
      if (r != 6)
        store(regIdx_t'(r));
    runProgram("load and store");
  endtask

  task automatic testMoveChain();
    beginProgram();
    loadImm(3'd0, 8'($urandom));
    for (int r = 1; r < 4; r++)
    begin
      move(regIdx_t'(r), regIdx_t'(r - 1));
      store(regIdx_t'(r));
    end
    move(REG_IDX_A, 3'd3);
    store(REG_IDX_A);
    repeat (20)
    begin
      move(randomReg(), randomSrc());
      store(randomSrc());
    end
    runProgram("register moves");
  endtask

  task automatic testAluOps();
    beginProgram();
    foreach (aluFns[f])
      repeat (6)
      begin
        loadImm(REG_IDX_A, 8'($urandom));
        loadImm(3'd1, 8'($urandom));
        aluWith(aluFns[f], $urandom_range(1) ? 3'd1 : REG_IDX_A);
        store(REG_IDX_A);
      end
    runProgram("ALU operations");
  endtask

  // Each JR either skips the marker store of D or not
  task automatic testFlagJumps();
    beginProgram();
    repeat (40)
    begin
      loadImm(REG_IDX_A, edgeByte());
      loadImm(3'd0, edgeByte());
      aluWith(aluFns[$urandom_range(4)], 3'd0);
      if ($urandom_range(1))
        incDec($urandom_range(1) ? REG_IDX_A : 3'd0, 1'($urandom));
      loadImm(3'd2, 8'($urandom));
      jumpIf(2'($urandom), 8'h01);
      store(3'd2);
    end
    runProgram("flag jumps");
  endtask

  task automatic testRandomStream();
    int n;
    n = 0;
    beginProgram();
    while (n < 200)
      n += randomInstr();
    runProgram("random stream");
  endtask

  task automatic testUnsupported();
    beginProgram();
    repeat (40)
    begin
      void'(randomInstr());
      if ($urandom_range(2) == 0)
        emit(oddOps[$urandom_range(9)]);
      store(randomSrc());
    end
    runProgram("unsupported opcodes");
  endtask

  // ----------------------------------------
  initial
  begin
    void'($urandom(32'h6be7));
    testLoadStore();
    testMoveChain();
    testAluOps();
    testFlagJumps();
    testRandomStream();
    testUnsupported();
    @(negedge iClock);
    check.printSummary();
    if (errorCount == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // Watchdog with a deadline that each program moves forward
  initial
  begin
    while ($time <= deadline)
      @(posedge iClock);
    $display("Timeout at %0d ns, the CPU did not halt in time", $time);
    check.printSummary();
    $display("Result: FAILED");
    $finish;
  end

endmodule
